// ==== filelist.f ====
+incdir+include
logic/rvPkg.sv
logic/rvDecoder.sv
logic/rvRegisterFile.sv
logic/rvAlu.sv
logic/rvControl.sv
logic/rvWriteback.sv
logic/femtoCore.sv
test/tbCore.sv

// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Width of a data word and of the register file entries
`define CORE_XLEN 32

// Internal PC and address adder width
`define CORE_ADDR_WIDTH 24

// First fetch address after reset
`define CORE_RESET_ADDR 32'h0000_0000

// Architectural registers, x0 included
`define CORE_REG_COUNT 32

`endif

// ==== logic/femtoCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module femtoCore import rvPkg::*; (
   input  wire        clk,
   input  wire        mem_rstrb,
   input  wire wordT  memRdata,
   input  wire        memRbusy,
   input  wire        memWbusy,
   output wordT       memAddr,
   output wordT       memWdata,
   output logic [3:0] memWmask,
   output logic       memRead
);

   instrKindT kind;
   regIdT     rdId;
   regIdT     rs1Id;
   regIdT     rs2Id;
   funct3HotT funct3Hot;
   logic      subOrArith;
   wordT      immI;
   wordT      immS;
   wordT      immB;
   wordT      immJ;
   wordT      immU;
   wordT      rs1Val;
   wordT      rs2Val;
   wordT      aluOut;
   wordT      aluSum;
   logic      branchTaken;
   logic      aluBusy;
   logic      instrLoad;
   logic      aluStart;
   logic      execPhase;
   addrT      pcPlus4;
   addrT      pcPlusImm;
   logic      regWrite;
   wordT      rdData;

   // Source indices straight from the incoming word
   assign rs1Id = memRdata[19:15];
   assign rs2Id = memRdata[24:20];

   rvDecoder decoder (
      .clk(clk), .instrLoad(instrLoad), .memRdata(memRdata),
      .kind(kind), .rdId(rdId), .funct3Hot(funct3Hot), .subOrArith(subOrArith),
      .immI(immI), .immS(immS), .immB(immB), .immJ(immJ), .immU(immU)
   );

   rvRegisterFile regFile (
      .clk(clk), .instrLoad(instrLoad), .rs1Id(rs1Id), .rs2Id(rs2Id),
      .regWrite(regWrite), .rdId(rdId), .rdData(rdData),
      .rs1Val(rs1Val), .rs2Val(rs2Val)
   );

   rvAlu alu (
      .clk(clk), .mem_rstrb(mem_rstrb), .aluStart(aluStart), .kind(kind),
      .funct3Hot(funct3Hot), .subOrArith(subOrArith), .rs1Val(rs1Val), .rs2Val(rs2Val),
      .immI(immI), .aluOut(aluOut), .aluSum(aluSum), .branchTaken(branchTaken),
      .aluBusy(aluBusy)
   );

   rvControl control (
      .clk(clk), .mem_rstrb(mem_rstrb), .kind(kind),
      .immI(immI), .immS(immS), .immB(immB), .immJ(immJ), .immU(immU),
      .rs1Val(rs1Val), .rs2Val(rs2Val), .aluSum(aluSum), .branchTaken(branchTaken),
      .aluBusy(aluBusy), .memRbusy(memRbusy), .memWbusy(memWbusy),
      .instrLoad(instrLoad), .aluStart(aluStart), .execPhase(execPhase),
      .pc(), .pcPlus4(pcPlus4), .pcPlusImm(pcPlusImm),
      .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask), .memRead(memRead)
   );

   rvWriteback writeback (
      .execPhase(execPhase), .kind(kind), .aluOut(aluOut), .immU(immU),
      .pcPlus4(pcPlus4), .pcPlusImm(pcPlusImm), .memRdata(memRdata),
      .regWrite(regWrite), .rdData(rdData)
   );

endmodule

`default_nettype wire

// ==== logic/rvAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module rvAlu import rvPkg::*; (
   input  wire            clk,
   input  wire            mem_rstrb,
   input  wire            aluStart,
   input  wire instrKindT kind,
   input  wire funct3HotT funct3Hot,
   input  wire            subOrArith,
   input  wire wordT      rs1Val,
   input  wire wordT      rs2Val,
   input  wire wordT      immI,
   output wordT           aluOut,
   output wordT           aluSum,
   output logic           branchTaken,
   output logic           aluBusy
);

   wordT                aluIn2;
   logic [`CORE_XLEN:0] aluMinus;  // One extra bit for the borrow
   logic                lt;
   logic                ltu;
   logic                eq;
   logic                isShift;
   wordT                shiftReg;
   logic [4:0]          shamt;     // Bits still to shift

   // Register form and branches compare rs2, the rest use immI
   assign aluIn2 = ((kind == kindAluReg) || (kind == kindBranch)) ? rs2Val : immI;

   assign aluSum = rs1Val + aluIn2;  // Also the JALR target

   // rs1 - rs2 in 33 bits gives the difference and all comparisons
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1Val} + (`CORE_XLEN+1)'(1);
   assign ltu      = aluMinus[`CORE_XLEN];
   assign eq       = (aluMinus[`CORE_XLEN-1:0] == '0);
   assign lt       = (rs1Val[`CORE_XLEN-1] ^ aluIn2[`CORE_XLEN-1]) ?
                     rs1Val[`CORE_XLEN-1] : ltu;  // Signs differ, rs1 sign decides

   assign isShift = funct3Hot[1] | funct3Hot[5];  // SLL, SRL, SRA

   assign aluOut =
      (funct3Hot[0] ? (subOrArith ? aluMinus[`CORE_XLEN-1:0] : aluSum) : '0) |
      (funct3Hot[2] ? {{(`CORE_XLEN-1){1'b0}}, lt}                       : '0) |
      (funct3Hot[3] ? {{(`CORE_XLEN-1){1'b0}}, ltu}                      : '0) |
      (funct3Hot[4] ? (rs1Val ^ aluIn2)                                  : '0) |
      (funct3Hot[6] ? (rs1Val | aluIn2)                                  : '0) |
      (funct3Hot[7] ? (rs1Val & aluIn2)                                  : '0) |
      (isShift      ? shiftReg                                           : '0);

   // Branch conditions for funct3 0, 1 and 4 to 7
   assign branchTaken = (funct3Hot[0] &  eq)  |  // BEQ
                        (funct3Hot[1] & ~eq)  |  // BNE
                        (funct3Hot[4] &  lt)  |  // BLT
                        (funct3Hot[5] & ~lt)  |  // BGE
                        (funct3Hot[6] &  ltu) |  // BLTU
                        (funct3Hot[7] & ~ltu);   // BGEU

   // Shift count loaded from the low five bits of the second operand
   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         shamt <= '0;
      end else if (aluStart && isShift) begin
         shamt <= aluIn2[4:0];
      end else if (shamt != '0) begin
         shamt <= shamt - 5'd1;
      end
   end

   // One bit position per cycle
   always_ff @(posedge clk) begin
      if (aluStart && isShift) begin
         shiftReg <= rs1Val;
      end else if (shamt != '0) begin
         if (funct3Hot[1]) begin
            shiftReg <= shiftReg << 1;  // SLL
         end else begin
            // SRA fills with the sign bit, SRL with zero
            shiftReg <= {subOrArith & shiftReg[`CORE_XLEN-1], shiftReg[`CORE_XLEN-1:1]};
         end
      end
   end

   // Busy also flags the start of a shift so the sequencer goes to wait
   assign aluBusy = (aluStart & isShift) | (shamt != '0);

endmodule

`default_nettype wire

// ==== logic/rvControl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module rvControl import rvPkg::*; (
   input  wire            clk,
   input  wire            mem_rstrb,
   input  wire instrKindT kind,
   input  wire wordT      immI,
   input  wire wordT      immS,
   input  wire wordT      immB,
   input  wire wordT      immJ,
   input  wire wordT      immU,
   input  wire wordT      rs1Val,
   input  wire wordT      rs2Val,
   input  wire wordT      aluSum,
   input  wire            branchTaken,
   input  wire            aluBusy,
   input  wire            memRbusy,
   input  wire            memWbusy,
   output logic           instrLoad,
   output logic           aluStart,
   output logic           execPhase,
   output addrT           pc,
   output addrT           pcPlus4,
   output addrT           pcPlusImm,
   output wordT           memAddr,
   output wordT           memWdata,
   output logic [3:0]     memWmask,
   output logic           memRead
);

   localparam addrT resetPc = addrT'(`CORE_RESET_ADDR);

   coreStateT state;
   logic      isLoad;
   logic      isStore;
   logic      isAlu;
   logic      isJal;
   logic      isJalr;
   logic      isAuipc;
   logic      isBranch;
   logic      needWait;
   addrT      jumpImm;
   addrT      lsAddr;
   addrT      nextPc;

   assign isLoad   = (kind == kindLoad);
   assign isStore  = (kind == kindStore);
   assign isAlu    = (kind == kindAluImm) || (kind == kindAluReg);
   assign isJal    = (kind == kindJal);
   assign isJalr   = (kind == kindJalr);
   assign isAuipc  = (kind == kindAuipc);
   assign isBranch = (kind == kindBranch);

   // One adder for JAL, AUIPC and branch targets
   assign jumpImm   = isJal   ? immJ[`CORE_ADDR_WIDTH-1:0] :
                      isAuipc ? immU[`CORE_ADDR_WIDTH-1:0] :
                                immB[`CORE_ADDR_WIDTH-1:0];
   assign pcPlusImm = pc + jumpImm;
   assign pcPlus4   = pc + addrT'(4);

   // Separate adder for the data address
   assign lsAddr = rs1Val[`CORE_ADDR_WIDTH-1:0] +
                   (isStore ? immS[`CORE_ADDR_WIDTH-1:0] : immI[`CORE_ADDR_WIDTH-1:0]);

   assign nextPc = isJalr                              ? {aluSum[`CORE_ADDR_WIDTH-1:1], 1'b0} :
                   (isJal || (isBranch && branchTaken)) ? pcPlusImm :
                                                          pcPlus4;

   // Data accesses always wait, shifts wait while the ALU is busy
   assign needWait = isLoad | isStore | aluBusy;

   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         state <= stWaitAluMem;  // Let the memory go idle first
         pc    <= resetPc;
      end else begin
         unique case (state)
            stFetch: state <= stWaitInstr;
            stWaitInstr: begin
               if (!memRbusy) begin
                  state <= stExecute;
               end
            end
            stExecute: begin
               pc    <= nextPc;
               state <= needWait ? stWaitAluMem : stFetch;
            end
            stWaitAluMem: begin
               if (!aluBusy && !memRbusy && !memWbusy) begin
                  state <= stFetch;
               end
            end
            default: state <= stWaitAluMem;
         endcase
      end
   end

   assign instrLoad = (state == stWaitInstr) & ~memRbusy;
   assign aluStart  = (state == stExecute) & isAlu;
   assign execPhase = (state == stExecute) | (state == stWaitAluMem);

   // PC drives the bus until the instruction is in
   assign memAddr  = wordT'(((state == stFetch) || (state == stWaitInstr)) ? pc : lsAddr);
   assign memWdata = rs2Val;
   assign memWmask = {4{(state == stExecute) & isStore}};  // Whole words only
   assign memRead  = (state == stFetch) | ((state == stExecute) & isLoad);

endmodule

`default_nettype wire

// ==== logic/rvDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvDecoder import rvPkg::*; (
   input  wire        clk,
   input  wire        instrLoad,
   input  wire wordT  memRdata,
   output instrKindT  kind,
   output regIdT      rdId,
   output funct3HotT  funct3Hot,
   output logic       subOrArith,
   output wordT       immI,
   output wordT       immS,
   output wordT       immB,
   output wordT       immJ,
   output wordT       immU
);

   // Bits 1:0 are always 11 in RV32I, so they are not kept
   logic [31:2] instr;

   always_ff @(posedge clk) begin
      if (instrLoad) begin
         instr <= memRdata[31:2];
      end
   end

   // Opcode class from bits 6 to 2
   always_comb begin
      case (instr[6:2])
         5'b00000: kind = kindLoad;    // rd <- mem[rs1 + immI]
         5'b00100: kind = kindAluImm;  // rd <- rs1 op immI
         5'b01000: kind = kindStore;   // mem[rs1 + immS] <- rs2
         5'b01100: kind = kindAluReg;  // rd <- rs1 op rs2
         5'b11011: kind = kindJal;
         5'b11001: kind = kindJalr;
         5'b01101: kind = kindLui;
         5'b00101: kind = kindAuipc;
         5'b11000: kind = kindBranch;
         default:  kind = kindOther;
      endcase
   end

   assign rdId      = instr[11:7];
   assign funct3Hot = funct3HotT'(8'b0000_0001 << instr[14:12]);

   // Bit 30 selects SUB over ADD only in register form, since in ADDI it is
   // an immediate bit. For shifts by funct3 101 it picks SRA in both forms
   assign subOrArith = instr[30] & (instr[5] | funct3Hot[5]);

   // Sign-extended immediate formats
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign immU = {instr[31:12], 12'b0};  // Upper 20 bits, low 12 cleared

endmodule

`default_nettype wire

// ==== logic/rvPkg.sv ====
`default_nettype none

`include "core_settings.svh"

package rvPkg;

   typedef logic [`CORE_XLEN-1:0]       wordT;   // Data word
   typedef logic [`CORE_ADDR_WIDTH-1:0] addrT;   // Internal address
   typedef logic [4:0]                  regIdT;  // Register index

   // Opcode classes, taken from instruction bits 6 to 2
   typedef enum logic [3:0] {
      kindLoad,
      kindAluImm,
      kindStore,
      kindAluReg,
      kindJal,
      kindJalr,
      kindLui,
      kindAuipc,
      kindBranch,
      kindOther    // Anything else just steps PC by 4
   } instrKindT;

   // funct3Hot[n] is set when funct3 == n
   typedef logic [7:0] funct3HotT;

   // Sequencer states, one-hot
   typedef enum logic [3:0] {
      stFetch      = 4'b0001,  // Fetch strobe
      stWaitInstr  = 4'b0010,  // Wait for the instruction word
      stExecute    = 4'b0100,  // PC update, data strobes
      stWaitAluMem = 4'b1000   // Shift or data access in progress
   } coreStateT;

endpackage

`default_nettype wire

// ==== logic/rvRegisterFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module rvRegisterFile import rvPkg::*; (
   input  wire        clk,
   input  wire        instrLoad,
   input  wire regIdT rs1Id,
   input  wire regIdT rs2Id,
   input  wire        regWrite,
   input  wire regIdT rdId,
   input  wire wordT  rdData,
   output wordT       rs1Val,
   output wordT       rs2Val
);

   // No storage for x0
   wordT regs [1:`CORE_REG_COUNT-1];

   always_ff @(posedge clk) begin
      if (regWrite && (rdId != '0)) begin
         regs[rdId] <= rdData;  // Writes to x0 dropped
      end
   end

   // Operands captured together with the instruction word
   always_ff @(posedge clk) begin
      if (instrLoad) begin
         rs1Val <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2Val <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

endmodule

`default_nettype wire

// ==== logic/rvWriteback.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvWriteback import rvPkg::*; (
   input  wire            execPhase,
   input  wire instrKindT kind,
   input  wire wordT      aluOut,
   input  wire wordT      immU,
   input  wire addrT      pcPlus4,
   input  wire addrT      pcPlusImm,
   input  wire wordT      memRdata,
   output logic           regWrite,
   output wordT           rdData
);

   // Result source per instruction kind
   always_comb begin
      case (kind)
         kindAluImm,
         kindAluReg: rdData = aluOut;
         kindLui:    rdData = immU;
         kindAuipc:  rdData = wordT'(pcPlusImm);  // Zero-extended address
         kindJal,
         kindJalr:   rdData = wordT'(pcPlus4);    // Link value
         kindLoad:   rdData = memRdata;           // Valid at the end of the wait
         default:    rdData = '0;
      endcase
   end

   // Written in both execute and wait, the last write holds the final value
   assign regWrite = execPhase &
                     (kind != kindStore) &
                     (kind != kindBranch) &
                     (kind != kindOther);

endmodule

`default_nettype wire

// ==== test/tbCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tbCore;

   localparam int memWords  = 2048;     // Byte addresses 0 to 0x1fff
   localparam int dataBase  = 32'h1000; // Word region for random loads and stores
   localparam int dumpOff   = 256;      // Register dump follows the 64 data words
   localparam int randItems = 80;

   logic        clk = 1'b0;
   logic        mem_rstrb;
   logic [31:0] memRdata;
   logic        memRbusy;
   logic        memWbusy;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic        memRead;

   logic [31:0] mem [memWords];     // Memory behind the DUT
   logic [31:0] refMem [memWords];  // Data as the ISA model sees it
   logic [31:0] prog [memWords];
   logic [31:0] xreg [32];          // Model register file
   logic [31:0] rngState = 32'hb729_6f89;
   logic [31:0] modelPc = `CORE_RESET_ADDR;
   logic [31:0] expLoadAddr;
   logic [31:0] expStoreAddr;
   logic [31:0] expStoreData;
   logic [31:0] busAddr;            // Bus values captured mid-cycle
   logic [31:0] busData;
   logic [31:0] readData;
   logic        readSeen;
   logic        writeSeen;
   logic        loadPending = 1'b0;
   logic        storePending = 1'b0;
   logic        fetchSeen = 1'b0;
   logic        runDone = 1'b0;
   int          progLen;
   int          endPc;
   int          rCnt = 0;           // Remaining busy cycles
   int          wCnt = 0;
   int          cycleCount = 0;
   int          cycleLimit = 0;

   femtoCore uut (
      .clk(clk), .mem_rstrb(mem_rstrb), .memRdata(memRdata), .memRbusy(memRbusy),
      .memWbusy(memWbusy), .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask),
      .memRead(memRead)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic int unsigned randBelow(input int unsigned n);
      rngState = xorshift(rngState);
      return rngState % n;
   endfunction

   function automatic string mismatchText(input string name, input logic [31:0] got,
                                          input logic [31:0] exp);
      return $sformatf("error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
   endfunction

   task automatic stopWithError(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   // Instruction encoders
   function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // SW
   endfunction

   function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // Register or immediate ALU op, rd never x30 or x31
   function automatic logic [31:0] randomAlu();
      logic [2:0] f3;
      logic [4:0] rd;
      logic       alt;
      f3  = 3'(randBelow(8));
      rd  = 5'(randBelow(30));
      alt = 1'(randBelow(2));
      if (randBelow(2) == 0)
         return rType({1'b0, alt & ((f3 == 3'd0) || (f3 == 3'd5)), 5'b0},
                      5'(randBelow(32)), 5'(randBelow(32)), f3, rd);
      if ((f3 == 3'd1) || (f3 == 3'd5))  // Shift amount in imm[4:0]
         return iType({1'b0, alt & (f3 == 3'd5), 5'b0, 5'(randBelow(32))},
                      5'(randBelow(32)), f3, rd, 7'b0010011);
      return iType(12'(randBelow(4096)), 5'(randBelow(32)), f3, rd, 7'b0010011);
   endfunction

   function automatic void emit(input logic [31:0] w);
      prog[progLen] = w;
      progLen++;
   endfunction

   task automatic buildProgram();
      int         pick;
      int         skip;
      logic [2:0] f3;
      logic [4:0] rs1;
      logic [4:0] rs2;
      progLen = 0;
      for (int r = 1; r <= 30; r++) begin  // LUI then ADDI
         emit({20'(randBelow(1 << 20)), 5'(r), 7'b0110111});
         emit(iType(12'(randBelow(4096)), 5'(r), 3'b000, 5'(r), 7'b0010011));
      end
      emit({20'(dataBase >> 12), 5'd31, 7'b0110111});  // x31 points at the data words
      for (int i = 0; i < randItems; i++) begin
         pick = randBelow(16);
         skip = 1 + randBelow(2);
         if (pick < 7) begin
            emit(randomAlu());
         end else if (pick == 7) begin
            emit({20'(randBelow(1 << 20)), 5'(randBelow(30)), 7'b0110111});  // LUI
         end else if (pick == 8) begin
            emit({20'(randBelow(2048)), 5'(randBelow(30)), 7'b0010111});     // AUIPC
         end else if (pick < 11) begin
            f3  = 3'(randBelow(6));
            f3  = (f3 < 3'd2) ? f3 : f3 + 3'd2;  // No funct3 2 or 3
            rs1 = 5'(randBelow(32));
            rs2 = (randBelow(4) == 0) ? rs1 : 5'(randBelow(32));
            emit(bType(13'(4 * (skip + 1)), rs2, rs1, f3));
            repeat (skip) emit(randomAlu());  // Skipped when taken
         end else if (pick == 11) begin
            emit(jType(21'(4 * (skip + 1)), 5'(randBelow(30))));
            repeat (skip) emit(randomAlu());
         end else if (pick == 12) begin
            emit({20'd0, 5'd30, 7'b0010111});  // x30 = own PC
            emit(iType(12'(12 + randBelow(2)), 5'd30, 3'b000, 5'(randBelow(30)),
                       7'b1100111));            // Odd offset checks bit 0 clear
            emit(randomAlu());
         end else if (pick == 13) begin
            emit(sType(12'(4 * randBelow(64)), 5'(randBelow(32)), 5'd31));
         end else if (pick == 14) begin
            emit(iType(12'(4 * randBelow(64)), 5'd31, 3'b010, 5'(randBelow(30)), 7'b0000011));
         end else begin
            emit({25'(randBelow(1 << 25)), 7'b0001111});  // Unsupported class, PC + 4
         end
      end
      for (int r = 0; r < 32; r++) begin
         emit(sType(12'(dumpOff + 4 * r), 5'(r), 5'd31));
      end
      endPc = 4 * progLen;
      emit(jType(21'd0, 5'd0));  // Spin here
   endtask

   function automatic void setReg(input logic [4:0] rd, input logic [31:0] v);
      if (rd != 5'd0)
         xreg[rd] = v;
   endfunction

   function automatic logic [31:0] aluResult(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return {31'b0, $signed(a) < $signed(b)};
         3'd3: return {31'b0, a < b};
         3'd4: return a ^ b;
         3'd5: begin
            if (alt)
               return $signed(a) >>> b[4:0];  // Sign fill
            return a >> b[4:0];
         end
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   // ISA model, one instruction per fetch
   task automatic stepModel();
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] immI;
      logic [31:0] nextPc;
      logic        taken;
      ins    = prog[modelPc[12:2]];
      a      = xreg[ins[19:15]];
      b      = xreg[ins[24:20]];
      immI   = {{20{ins[31]}}, ins[31:20]};
      nextPc = modelPc + 32'd4;
      case (ins[6:0])
         7'b0110111: setReg(ins[11:7], {ins[31:12], 12'b0});            // LUI
         7'b0010111: setReg(ins[11:7], modelPc + {ins[31:12], 12'b0});  // AUIPC
         7'b1101111: begin
            nextPc = modelPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            setReg(ins[11:7], modelPc + 32'd4);
         end
         7'b1100111: begin
            nextPc = (a + immI) & ~32'd1;  // Target taken before rd is written
            setReg(ins[11:7], modelPc + 32'd4);
         end
         7'b1100011: begin
            case (ins[14:12])
               3'd0: taken = (a == b);
               3'd1: taken = (a != b);
               3'd4: taken = ($signed(a) < $signed(b));
               3'd5: taken = ($signed(a) >= $signed(b));
               3'd6: taken = (a < b);
               default: taken = (a >= b);
            endcase
            if (taken)
               nextPc = modelPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         end
         7'b0000011: begin
            expLoadAddr = a + immI;
            loadPending = 1'b1;
            setReg(ins[11:7], refMem[expLoadAddr[12:2]]);
         end
         7'b0100011: begin
            expStoreAddr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            expStoreData = b;
            storePending = 1'b1;
            refMem[expStoreAddr[12:2]] = b;
         end
         7'b0010011: setReg(ins[11:7], aluResult(ins[14:12], ins[30] & (ins[14:12] == 3'd5),
                                                 a, immI));
         7'b0110011: setReg(ins[11:7], aluResult(ins[14:12], ins[30], a, b));
         default: ;  // No register write
      endcase
      modelPc = nextPc;
   endtask

   task automatic checkBus();
      if (memRbusy || memWbusy) begin
         assert (!readSeen && !writeSeen)
            else stopWithError("Memory strobe raised while the memory reports busy");
      end
      if (readSeen && loadPending) begin
         assert (busAddr === expLoadAddr)
            else stopWithError(mismatchText("memAddr", busAddr, expLoadAddr));
         loadPending = 1'b0;
      end else if (readSeen) begin
         assert (!storePending) else stopWithError("Next fetch came before the store");
         if (!fetchSeen) begin
            assert (busAddr === `CORE_RESET_ADDR)
               else stopWithError(mismatchText("memAddr", busAddr, `CORE_RESET_ADDR));
            fetchSeen = 1'b1;
         end
         assert (busAddr === modelPc) else stopWithError(mismatchText("memAddr", busAddr, modelPc));
         if (modelPc == endPc)
            runDone = 1'b1;
         else
            stepModel();
      end
      if (writeSeen) begin
         assert (storePending) else stopWithError("Write strobe without a store instruction");
         assert (memWmask === 4'b1111)
            else stopWithError(mismatchText("memWmask", 32'(memWmask), 32'hf));
         assert (busAddr === expStoreAddr)
            else stopWithError(mismatchText("memAddr", busAddr, expStoreAddr));
         assert (busData === expStoreData)
            else stopWithError(mismatchText("memWdata", busData, expStoreData));
         storePending = 1'b0;
      end
   endtask

   // Each access may be followed by 0 to 3 busy cycles
   task automatic serveMemory();
      if (readSeen) begin
         readData = mem[busAddr[12:2]];
         rCnt     = randBelow(4);
      end else if (rCnt != 0) begin
         rCnt--;
      end
      memRbusy = (rCnt != 0);
      memRdata = memRbusy ? 'x : readData;  // Not valid until busy drops
      if (writeSeen) begin
         mem[busAddr[12:2]] = busData;
         wCnt               = randBelow(4);
      end else if (wCnt != 0) begin
         wCnt--;
      end
      memWbusy = (wCnt != 0);
   endtask

   // Bus sampled at the falling edge, answered 1 ns after the rising edge
   always begin
      @(negedge clk);
      readSeen  = (memRead !== 1'b0);
      writeSeen = (memWmask !== 4'b0000);
      busAddr   = memAddr;
      busData   = memWdata;
      if (mem_rstrb) begin
         assert (!readSeen && !writeSeen) else stopWithError("Memory strobe active during reset");
      end else begin
         checkBus();
      end
      @(posedge clk);
      #1;
      serveMemory();
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > cycleLimit)
         stopWithError($sformatf("Timeout after %0d cycles, program end not reached", cycleCount));
   end

   initial begin
      mem_rstrb = 1'b1;
      memRdata  = '0;
      memRbusy  = 1'b0;
      memWbusy  = 1'b0;
      readData  = '0;
      for (int i = 0; i < memWords; i++) begin
         mem[i]    = (i * 32'h9e37_79b9) ^ 32'h5bd1_e995;  // Distinct per address
         refMem[i] = mem[i];
      end
      for (int r = 0; r < 32; r++) begin
         xreg[r] = '0;
      end
      buildProgram();
      for (int i = 0; i < progLen; i++) begin
         mem[i] = prog[i];
      end
      // Sequence, longest shift and two stalls per instruction, plus reset
      cycleLimit = progLen * (4 + 32 + 2 * 3) + 200;
      repeat (10) @(posedge clk);
      #1;
      mem_rstrb = 1'b0;
      wait (runDone);
      for (int i = dataBase / 4; i < dataBase / 4 + 96; i++) begin
         assert (mem[i] === refMem[i])
            else stopWithError(mismatchText($sformatf("mem[%0d]", i), mem[i], refMem[i]));
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire
